// File: rtl/periph_xbar_pkg.sv
/*
  Address map, target ids and address layout of the peripheral crossbar.
  The target index field is 4 bits wide, so at most 16 targets exist.
  Cluster n sits at CLUSTER_BASE + (n << 22).
*/
package periph_xbar_pkg;

  localparam int unsigned ADDR_W = 32;

  localparam logic [ADDR_W-1:0] CLUSTER_BASE = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] ALIAS_BASE   = 32'h1200_0000;
  // 1 MB peripheral window inside each cluster
  localparam logic [ADDR_W-1:0] PERIPH_OFFS  = 32'h0020_0000;

  localparam int unsigned ROUTE_LSB = 10;
  localparam int unsigned ROUTE_MSB = 13;

  typedef logic [ROUTE_MSB-ROUTE_LSB:0] tgt_idx_t;

  localparam tgt_idx_t    TGT_EU_ID   = 4'd0;
  localparam int unsigned EU_PLUGS    = 2;
  localparam tgt_idx_t    TGT_CFG_ID  = 4'd2;
  localparam tgt_idx_t    TGT_HWPE_ID = 4'd3;
  localparam tgt_idx_t    TGT_EXT_ID  = 4'd8;
  localparam tgt_idx_t    TGT_ERR_ID  = 4'd9;

  typedef struct packed {
    logic [9:0] cluster;
    logic [1:0] region;
    logic [5:0] pad;
    tgt_idx_t   index;
    logic [9:0] offset;
  } periph_fields_t;

  // flat word for window compares, field view for routing
  typedef union packed {
    logic [ADDR_W-1:0] word;
    periph_fields_t    f;
  } periph_addr_u;

endpackage

// File: rtl/periph_addr_decode.sv
/*
  Combinational address decoder for one initiator.
  Addresses outside the own cluster (or the alias window when enabled)
  go to the external target; malformed peripheral addresses go to the
  error target. Indices always come out below NB_TARGETS.
*/
`timescale 1ns/1ps

module periph_addr_decode #(
  parameter int unsigned NB_TARGETS = 10
) (
  input  logic [periph_xbar_pkg::ADDR_W-1:0] addr_i,
  input  logic [5:0]                         cluster_id_i,
  input  logic                               alias_en_i,
  input  logic                               hwpe_en_i,
  output periph_xbar_pkg::tgt_idx_t          tgt_idx_o
);
  import periph_xbar_pkg::*;

  periph_addr_u      addr;
  logic [ADDR_W-1:0] own_base;
  logic              own_hit;
  logic              alias_hit;
  tgt_idx_t          idx;

  assign addr      = addr_i;
  assign idx       = addr.f.index;
  assign own_base  = CLUSTER_BASE + (ADDR_W'(cluster_id_i) << 22);
  assign own_hit   = addr.word[ADDR_W-1:22] == own_base[ADDR_W-1:22];
  assign alias_hit = alias_en_i && (addr.word[ADDR_W-1:22] == ALIAS_BASE[ADDR_W-1:22]);

  always_comb begin
    if (!(own_hit || alias_hit)) begin
      tgt_idx_o = TGT_EXT_ID;
    end else if (addr.f.region != PERIPH_OFFS[21:20] || addr.f.pad != '0 ||
                 int'(idx) >= NB_TARGETS) begin
      tgt_idx_o = TGT_ERR_ID;
    end else if (idx == TGT_EXT_ID) begin
      // a direct hit on the external port would loop back out
      tgt_idx_o = TGT_ERR_ID;
    end else if (idx == TGT_HWPE_ID && !hwpe_en_i) begin
      tgt_idx_o = TGT_ERR_ID;
    end else if (tgt_idx_t'(idx - TGT_EU_ID) < tgt_idx_t'(EU_PLUGS)) begin
      // all event unit plugs share one port
      tgt_idx_o = TGT_EU_ID;
    end else begin
      tgt_idx_o = idx;
    end
  end

endmodule

// File: rtl/periph_rr_arbiter.sv
/*
  Round-robin arbiter in front of one target.
  Initiators must hold req until granted. A winner stalled by the target
  keeps the target until its transfer, and the pointer only moves after
  a transfer.
*/
`timescale 1ns/1ps

module periph_rr_arbiter #(
  parameter int unsigned  NB_INIT = 4,
  localparam int unsigned SEL_W   = (NB_INIT > 1) ? $clog2(NB_INIT) : 1
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic [NB_INIT-1:0] req_i,
  output logic [NB_INIT-1:0] gnt_o,
  input  logic               tgt_gnt_i,
  output logic               tgt_req_o,
  output logic [SEL_W-1:0]   sel_o
);

  logic [SEL_W-1:0] ptr_q;
  logic [SEL_W-1:0] hold_sel_q;
  logic             hold_q;
  logic             xfer;

  // first requester at or after the pointer
  always_comb begin
    int   cand;
    logic found;
    found = 1'b0;
    sel_o = ptr_q;
    for (int k = 0; k < NB_INIT; k++) begin
      cand = (int'(ptr_q) + k) % NB_INIT;
      if (!found && req_i[cand]) begin
        found = 1'b1;
        sel_o = SEL_W'(cand);
      end
    end
    if (hold_q) begin
      sel_o = hold_sel_q;
    end
  end

  assign tgt_req_o = |req_i;
  assign xfer      = tgt_req_o & tgt_gnt_i;

  always_comb begin
    gnt_o        = '0;
    gnt_o[sel_o] = xfer;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q  <= '0;
      hold_q <= 1'b0;
    end else begin
      hold_q <= tgt_req_o & ~tgt_gnt_i;
      if (xfer) begin
        ptr_q <= (int'(sel_o) == NB_INIT - 1) ? '0 : sel_o + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tgt_req_o && !tgt_gnt_i) begin
      hold_sel_q <= sel_o;
    end
  end

endmodule

// File: rtl/periph_resp_router.sv
/*
  Response return for one initiator.
  Relies on at most one target answering this initiator per cycle;
  responses cannot be stalled.
*/
`timescale 1ns/1ps

module periph_resp_router #(
  parameter int unsigned NB_INIT    = 4,
  parameter int unsigned NB_TARGETS = 10,
  parameter int unsigned DATA_W     = 32,
  parameter int unsigned INIT_ID    = 0
) (
  input  logic [NB_TARGETS-1:0]             tgt_rvalid_i,
  input  logic [NB_TARGETS-1:0][NB_INIT-1:0] tgt_rid_i,
  input  logic [NB_TARGETS-1:0][DATA_W-1:0]  tgt_rdata_i,
  input  logic [NB_TARGETS-1:0]             tgt_ropc_i,
  output logic                              rvalid_o,
  output logic [DATA_W-1:0]                 rdata_o,
  output logic                              ropc_o
);

  localparam int unsigned IDX_W = $clog2(NB_TARGETS);

  logic [NB_TARGETS-1:0] match;
  logic [IDX_W-1:0]      hit_idx;

  for (genvar t = 0; t < NB_TARGETS; t++) begin : gen_match
    assign match[t] = tgt_rvalid_i[t] && (tgt_rid_i[t] == (NB_INIT'(1) << INIT_ID));
  end

  // one-hot to binary
  always_comb begin
    hit_idx = '0;
    for (int t = 0; t < NB_TARGETS; t++) begin
      if (match[t]) begin
        hit_idx = IDX_W'(t);
      end
    end
  end

  assign rvalid_o = |match;
  assign rdata_o  = tgt_rdata_i[hit_idx];
  assign ropc_o   = tgt_ropc_i[hit_idx];

endmodule

// File: rtl/periph_cfg_regs.sv
/*
  Configuration target of the crossbar.
  Offset 0x0 holds the cluster id in bits 5:0, offset 0x4 holds alias
  enable in bit 0 and accelerator present in bit 1. Only byte enable 0
  is honoured on writes. One wait state before gnt, rvalid one cycle
  after gnt.
*/
`timescale 1ns/1ps

module periph_cfg_regs #(
  parameter int unsigned NB_INIT        = 4,
  parameter int unsigned DATA_W         = 32,
  parameter logic [5:0]  CLUSTER_ID_RST = 6'd0
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               req_i,
  input  logic [periph_xbar_pkg::ADDR_W-1:0] addr_i,
  input  logic                               we_n_i,
  input  logic [DATA_W/8-1:0]                be_i,
  input  logic [DATA_W-1:0]                  wdata_i,
  input  logic [NB_INIT-1:0]                 id_i,
  output logic                               gnt_o,
  output logic                               rvalid_o,
  output logic [DATA_W-1:0]                  rdata_o,
  output logic [NB_INIT-1:0]                 rid_o,
  output logic                               ropc_o,
  output logic [5:0]                         cluster_id_o,
  output logic                               alias_en_o,
  output logic                               hwpe_en_o
);
  import periph_xbar_pkg::*;

  logic [ROUTE_LSB-1:0] offs;
  logic                 xfer;
  logic                 sel_id;
  logic                 sel_ctrl;
  logic [DATA_W-1:0]    rd_val;

  assign offs     = addr_i[ROUTE_LSB-1:0];
  assign sel_id   = offs == 'h0;
  assign sel_ctrl = offs == 'h4;
  assign xfer     = req_i & gnt_o;

  always_comb begin
    rd_val = '0;
    if (sel_id) begin
      rd_val[5:0] = cluster_id_o;
    end else if (sel_ctrl) begin
      rd_val[1:0] = {hwpe_en_o, alias_en_o};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gnt_o        <= 1'b0;
      rvalid_o     <= 1'b0;
      cluster_id_o <= CLUSTER_ID_RST;
      alias_en_o   <= 1'b0;
      hwpe_en_o    <= 1'b1;
    end else begin
      // grant one cycle after req shows up
      gnt_o    <= req_i & ~gnt_o;
      rvalid_o <= xfer;
      if (xfer && !we_n_i && be_i[0]) begin
        if (sel_id) begin
          cluster_id_o <= wdata_i[5:0];
        end else if (sel_ctrl) begin
          alias_en_o <= wdata_i[0];
          hwpe_en_o  <= wdata_i[1];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      rdata_o <= rd_val;
      rid_o   <= id_i;
      ropc_o  <= ~(sel_id | sel_ctrl);
    end
  end

endmodule

// File: rtl/periph_xbar.sv
/*
  Peripheral crossbar, NB_INIT initiators to NB_TARGETS targets.
  Request and response paths are purely combinational. Responses are
  always accepted; tgt_id carries the one-hot id of the initiator.
*/
`timescale 1ns/1ps

module periph_xbar #(
  parameter int unsigned NB_INIT    = 4,
  parameter int unsigned NB_TARGETS = 10,
  parameter int unsigned DATA_W     = 32
) (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  input  logic [5:0]                                           cluster_id_i,
  input  logic                                                 alias_en_i,
  input  logic                                                 hwpe_en_i,
  input  logic [NB_INIT-1:0]                                   init_req_i,
  input  logic [NB_INIT-1:0][periph_xbar_pkg::ADDR_W-1:0]      init_addr_i,
  input  logic [NB_INIT-1:0]                                   init_we_n_i,
  input  logic [NB_INIT-1:0][DATA_W/8-1:0]                     init_be_i,
  input  logic [NB_INIT-1:0][DATA_W-1:0]                       init_wdata_i,
  output logic [NB_INIT-1:0]                                   init_gnt_o,
  output logic [NB_INIT-1:0]                                   init_rvalid_o,
  output logic [NB_INIT-1:0][DATA_W-1:0]                       init_rdata_o,
  output logic [NB_INIT-1:0]                                   init_ropc_o,
  output logic [NB_TARGETS-1:0]                                tgt_req_o,
  output logic [NB_TARGETS-1:0][periph_xbar_pkg::ADDR_W-1:0]   tgt_addr_o,
  output logic [NB_TARGETS-1:0]                                tgt_we_n_o,
  output logic [NB_TARGETS-1:0][DATA_W/8-1:0]                  tgt_be_o,
  output logic [NB_TARGETS-1:0][DATA_W-1:0]                    tgt_wdata_o,
  output logic [NB_TARGETS-1:0][NB_INIT-1:0]                   tgt_id_o,
  input  logic [NB_TARGETS-1:0]                                tgt_gnt_i,
  input  logic [NB_TARGETS-1:0]                                tgt_rvalid_i,
  input  logic [NB_TARGETS-1:0][DATA_W-1:0]                    tgt_rdata_i,
  input  logic [NB_TARGETS-1:0][NB_INIT-1:0]                   tgt_rid_i,
  input  logic [NB_TARGETS-1:0]                                tgt_ropc_i
);
  import periph_xbar_pkg::*;

  localparam int unsigned SEL_W = (NB_INIT > 1) ? $clog2(NB_INIT) : 1;

  tgt_idx_t [NB_INIT-1:0]                 dec_idx;
  logic     [NB_TARGETS-1:0][NB_INIT-1:0] req_m;
  logic     [NB_TARGETS-1:0][NB_INIT-1:0] gnt_m;
  logic     [NB_TARGETS-1:0][SEL_W-1:0]   win;

  for (genvar i = 0; i < NB_INIT; i++) begin : gen_init
    periph_addr_decode #(
      .NB_TARGETS (NB_TARGETS)
    ) i_decode (
      .addr_i       (init_addr_i[i]),
      .cluster_id_i (cluster_id_i),
      .alias_en_i   (alias_en_i),
      .hwpe_en_i    (hwpe_en_i),
      .tgt_idx_o    (dec_idx[i])
    );

    // only the addressed target can grant this initiator
    assign init_gnt_o[i] = gnt_m[dec_idx[i]][i];

    periph_resp_router #(
      .NB_INIT    (NB_INIT),
      .NB_TARGETS (NB_TARGETS),
      .DATA_W     (DATA_W),
      .INIT_ID    (i)
    ) i_resp (
      .tgt_rvalid_i (tgt_rvalid_i),
      .tgt_rid_i    (tgt_rid_i),
      .tgt_rdata_i  (tgt_rdata_i),
      .tgt_ropc_i   (tgt_ropc_i),
      .rvalid_o     (init_rvalid_o[i]),
      .rdata_o      (init_rdata_o[i]),
      .ropc_o       (init_ropc_o[i])
    );
  end

  for (genvar t = 0; t < NB_TARGETS; t++) begin : gen_tgt
    for (genvar i = 0; i < NB_INIT; i++) begin : gen_req
      assign req_m[t][i] = init_req_i[i] && (dec_idx[i] == tgt_idx_t'(t));
    end

    periph_rr_arbiter #(
      .NB_INIT (NB_INIT)
    ) i_arb (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .req_i     (req_m[t]),
      .gnt_o     (gnt_m[t]),
      .tgt_gnt_i (tgt_gnt_i[t]),
      .tgt_req_o (tgt_req_o[t]),
      .sel_o     (win[t])
    );

    assign tgt_addr_o[t]  = init_addr_i[win[t]];
    assign tgt_we_n_o[t]  = init_we_n_i[win[t]];
    assign tgt_be_o[t]    = init_be_i[win[t]];
    assign tgt_wdata_o[t] = init_wdata_i[win[t]];
    assign tgt_id_o[t]    = NB_INIT'(1) << win[t];
  end

endmodule

// File: rtl/periph_subsys_top.sv
/*
  Peripheral subsystem: crossbar plus configuration registers.
  External port k carries crossbar target k below TGT_CFG_ID and k+1
  from there on. NB_TARGETS must lie between 10 and 16.
*/
`timescale 1ns/1ps

module periph_subsys_top #(
  parameter int unsigned NB_INIT        = 4,
  parameter int unsigned NB_TARGETS     = 10,
  parameter int unsigned DATA_W         = 32,
  parameter logic [5:0]  CLUSTER_ID_RST = 6'd0
) (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  input  logic [NB_INIT-1:0]                                   init_req_i,
  input  logic [NB_INIT-1:0][periph_xbar_pkg::ADDR_W-1:0]      init_addr_i,
  input  logic [NB_INIT-1:0]                                   init_we_n_i,
  input  logic [NB_INIT-1:0][DATA_W/8-1:0]                     init_be_i,
  input  logic [NB_INIT-1:0][DATA_W-1:0]                       init_wdata_i,
  output logic [NB_INIT-1:0]                                   init_gnt_o,
  output logic [NB_INIT-1:0]                                   init_rvalid_o,
  output logic [NB_INIT-1:0][DATA_W-1:0]                       init_rdata_o,
  output logic [NB_INIT-1:0]                                   init_ropc_o,
  output logic [NB_TARGETS-2:0]                                tgt_req_o,
  output logic [NB_TARGETS-2:0][periph_xbar_pkg::ADDR_W-1:0]   tgt_addr_o,
  output logic [NB_TARGETS-2:0]                                tgt_we_n_o,
  output logic [NB_TARGETS-2:0][DATA_W/8-1:0]                  tgt_be_o,
  output logic [NB_TARGETS-2:0][DATA_W-1:0]                    tgt_wdata_o,
  output logic [NB_TARGETS-2:0][NB_INIT-1:0]                   tgt_id_o,
  input  logic [NB_TARGETS-2:0]                                tgt_gnt_i,
  input  logic [NB_TARGETS-2:0]                                tgt_rvalid_i,
  input  logic [NB_TARGETS-2:0][DATA_W-1:0]                    tgt_rdata_i,
  input  logic [NB_TARGETS-2:0][NB_INIT-1:0]                   tgt_rid_i,
  input  logic [NB_TARGETS-2:0]                                tgt_ropc_i
);
  import periph_xbar_pkg::*;

  logic [5:0] cluster_id;
  logic       alias_en;
  logic       hwpe_en;

  // crossbar side of every target, config block included
  logic [NB_TARGETS-1:0]              x_req, x_we_n, x_gnt, x_rvalid, x_ropc;
  logic [NB_TARGETS-1:0][ADDR_W-1:0]  x_addr;
  logic [NB_TARGETS-1:0][DATA_W/8-1:0] x_be;
  logic [NB_TARGETS-1:0][DATA_W-1:0]  x_wdata, x_rdata;
  logic [NB_TARGETS-1:0][NB_INIT-1:0] x_id, x_rid;

  periph_xbar #(
    .NB_INIT    (NB_INIT),
    .NB_TARGETS (NB_TARGETS),
    .DATA_W     (DATA_W)
  ) i_xbar (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .cluster_id_i  (cluster_id),
    .alias_en_i    (alias_en),
    .hwpe_en_i     (hwpe_en),
    .init_req_i    (init_req_i),
    .init_addr_i   (init_addr_i),
    .init_we_n_i   (init_we_n_i),
    .init_be_i     (init_be_i),
    .init_wdata_i  (init_wdata_i),
    .init_gnt_o    (init_gnt_o),
    .init_rvalid_o (init_rvalid_o),
    .init_rdata_o  (init_rdata_o),
    .init_ropc_o   (init_ropc_o),
    .tgt_req_o     (x_req),
    .tgt_addr_o    (x_addr),
    .tgt_we_n_o    (x_we_n),
    .tgt_be_o      (x_be),
    .tgt_wdata_o   (x_wdata),
    .tgt_id_o      (x_id),
    .tgt_gnt_i     (x_gnt),
    .tgt_rvalid_i  (x_rvalid),
    .tgt_rdata_i   (x_rdata),
    .tgt_rid_i     (x_rid),
    .tgt_ropc_i    (x_ropc)
  );

  periph_cfg_regs #(
    .NB_INIT        (NB_INIT),
    .DATA_W         (DATA_W),
    .CLUSTER_ID_RST (CLUSTER_ID_RST)
  ) i_cfg_regs (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (x_req[TGT_CFG_ID]),
    .addr_i       (x_addr[TGT_CFG_ID]),
    .we_n_i       (x_we_n[TGT_CFG_ID]),
    .be_i         (x_be[TGT_CFG_ID]),
    .wdata_i      (x_wdata[TGT_CFG_ID]),
    .id_i         (x_id[TGT_CFG_ID]),
    .gnt_o        (x_gnt[TGT_CFG_ID]),
    .rvalid_o     (x_rvalid[TGT_CFG_ID]),
    .rdata_o      (x_rdata[TGT_CFG_ID]),
    .rid_o        (x_rid[TGT_CFG_ID]),
    .ropc_o       (x_ropc[TGT_CFG_ID]),
    .cluster_id_o (cluster_id),
    .alias_en_o   (alias_en),
    .hwpe_en_o    (hwpe_en)
  );

  // skip over the config target when numbering external ports
  for (genvar k = 0; k < NB_TARGETS - 1; k++) begin : gen_ext
    localparam int unsigned T = (k < TGT_CFG_ID) ? k : k + 1;
    assign tgt_req_o[k]   = x_req[T];
    assign tgt_addr_o[k]  = x_addr[T];
    assign tgt_we_n_o[k]  = x_we_n[T];
    assign tgt_be_o[k]    = x_be[T];
    assign tgt_wdata_o[k] = x_wdata[T];
    assign tgt_id_o[k]    = x_id[T];
    assign x_gnt[T]       = tgt_gnt_i[k];
    assign x_rvalid[T]    = tgt_rvalid_i[k];
    assign x_rdata[T]     = tgt_rdata_i[k];
    assign x_rid[T]       = tgt_rid_i[k];
    assign x_ropc[T]      = tgt_ropc_i[k];
  end

endmodule

// File: tb/tb_clk_gen.sv
/*
  Clock and reset source for the testbench.
  Reset is released on a rising edge after RST_CYCLES cycles.
*/
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned HALF_NS    = 50,
  parameter int unsigned RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: tb/tb_target_model.sv
/*
  Behavioral models of all external targets.
  Grants at random, answers one cycle after each transfer with rdata equal
  to the address XOR the crossbar target number. Only the error target
  answers with ropc set. Assumes DATA_W equals the address width.
*/
`timescale 1ns/1ps

module tb_target_model #(
  parameter int unsigned  NB_INIT    = 4,
  parameter int unsigned  NB_TARGETS = 10,
  parameter int unsigned  DATA_W     = 32,
  localparam int unsigned NB_EXT     = NB_TARGETS - 1
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic [NB_EXT-1:0]              req_i,
  input  logic [NB_EXT-1:0][31:0]        addr_i,
  input  logic [NB_EXT-1:0][NB_INIT-1:0] id_i,
  output logic [NB_EXT-1:0]              gnt_o,
  output logic [NB_EXT-1:0]              rvalid_o,
  output logic [NB_EXT-1:0][DATA_W-1:0]  rdata_o,
  output logic [NB_EXT-1:0][NB_INIT-1:0] rid_o,
  output logic [NB_EXT-1:0]              ropc_o
);

  integer seed = 32'hea863a2d;

  always @(posedge clk_i or negedge arst_n_i) begin
    logic [31:0] rnd;
    int          tnum;
    if (!arst_n_i) begin
      gnt_o    <= '0;
      rvalid_o <= '0;
      rdata_o  <= '0;
      rid_o    <= '0;
      ropc_o   <= '0;
    end else begin
      rnd = $random(seed);
      // roughly three grants in four cycles
      gnt_o <= rnd[NB_EXT-1:0] | rnd[16 +: NB_EXT];
      for (int k = 0; k < NB_EXT; k++) begin
        // port k stands for crossbar target k, or k+1 past the config block
        tnum = (k < 2) ? k : k + 1;
        rvalid_o[k] <= req_i[k] & gnt_o[k];
        if (req_i[k] && gnt_o[k]) begin
          rid_o[k]   <= id_i[k];
          rdata_o[k] <= addr_i[k] ^ tnum;
          ropc_o[k]  <= (tnum == 9);
        end
      end
    end
  end

endmodule

// File: tb/periph_subsys_tb.sv
/*
  Testbench of the peripheral subsystem with 4 initiators and 10 targets.
  A monitor checks every transfer and response against a decode model
  and a shadow copy of the configuration registers.
*/
`timescale 1ns/1ps

module periph_subsys_tb;

  localparam int NB_INIT    = 4;
  localparam int NB_TARGETS = 10;
  localparam int NB_EXT     = NB_TARGETS - 1;
  localparam int TMO        = 200;

  logic clk, rst_n;
  logic [NB_INIT-1:0]             init_req, init_we_n, init_gnt, init_rvalid, init_ropc;
  logic [NB_INIT-1:0][31:0]       init_addr, init_wdata, init_rdata;
  logic [NB_INIT-1:0][3:0]        init_be;
  logic [NB_EXT-1:0]              tgt_req, tgt_we_n, tgt_gnt, tgt_rvalid, tgt_ropc;
  logic [NB_EXT-1:0][31:0]        tgt_addr, tgt_wdata, tgt_rdata;
  logic [NB_EXT-1:0][3:0]         tgt_be;
  logic [NB_EXT-1:0][NB_INIT-1:0] tgt_id, tgt_rid;

  // shadow of the config block and per-initiator expectations
  logic [5:0]         sh_cid = 6'd0;
  logic               sh_alias = 1'b0;
  logic               sh_hwpe = 1'b1;
  logic [NB_INIT-1:0] pend = '0;
  logic [NB_INIT-1:0] chk_data, exp_ropc;
  logic [NB_INIT-1:0][31:0] exp_rdata;
  logic               fair_mode = 1'b0;
  logic [NB_INIT-1:0] waiting = '0;
  logic [NB_INIT-1:0][NB_INIT-1:0] since = '0;

  integer seed = 32'hea863a2d;
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     errs_at_start;
  string  cur_test = "reset";

  tb_clk_gen #(.HALF_NS(50), .RST_CYCLES(10)) i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  periph_subsys_top #(
    .NB_INIT    (NB_INIT),
    .NB_TARGETS (NB_TARGETS),
    .DATA_W     (32)
  ) i_periph_subsys_top (
    .clk_i (clk), .arst_n_i (rst_n),
    .init_req_i (init_req), .init_addr_i (init_addr), .init_we_n_i (init_we_n),
    .init_be_i (init_be), .init_wdata_i (init_wdata), .init_gnt_o (init_gnt),
    .init_rvalid_o (init_rvalid), .init_rdata_o (init_rdata), .init_ropc_o (init_ropc),
    .tgt_req_o (tgt_req), .tgt_addr_o (tgt_addr), .tgt_we_n_o (tgt_we_n),
    .tgt_be_o (tgt_be), .tgt_wdata_o (tgt_wdata), .tgt_id_o (tgt_id),
    .tgt_gnt_i (tgt_gnt), .tgt_rvalid_i (tgt_rvalid), .tgt_rdata_i (tgt_rdata),
    .tgt_rid_i (tgt_rid), .tgt_ropc_i (tgt_ropc)
  );

  tb_target_model #(.NB_INIT(NB_INIT), .NB_TARGETS(NB_TARGETS), .DATA_W(32)) i_targets (
    .clk_i (clk), .arst_n_i (rst_n), .req_i (tgt_req), .addr_i (tgt_addr), .id_i (tgt_id),
    .gnt_o (tgt_gnt), .rvalid_o (tgt_rvalid), .rdata_o (tgt_rdata), .rid_o (tgt_rid),
    .ropc_o (tgt_ropc)
  );

  // reference decode with cluster n at 0x1000_0000 + n<<22 and the alias at 0x1200_0000
  function automatic int exp_target(input logic [31:0] a, input logic [5:0] cid,
                                    input logic al, input logic hw);
    int idx;
    idx = int'(a[13:10]);
    if (a[31:22] != (10'h040 + {4'b0, cid}) && !(al && a[31:22] == 10'h048)) return 8;
    if (a[21:20] != 2'b10 || a[19:14] != 6'd0 || idx >= NB_TARGETS) return 9;
    if (idx == 8 || (idx == 3 && !hw)) return 9;
    if (idx < 2) return 0;
    return idx;
  endfunction

  function automatic logic [31:0] periph_addr(input logic [5:0] cid, input int idx,
                                              input int offs);
    return 32'h1020_0000 + ({26'd0, cid} << 22) + (idx << 10) + offs;
  endfunction

  task automatic flag_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("CHECK FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("ERROR in %s: %s", cur_test, msg);
  endtask

  // checks each transfer where it happens and each response against it
  always @(posedge clk) begin
    int t;
    int k;
    logic [NB_INIT-1:0] oh;
    if (rst_n) begin
      for (int i = 0; i < NB_INIT; i++) begin
        oh = NB_INIT'(1) << i;
        assert (init_req[i] || !init_gnt[i])
        else note_failure($sformatf("gnt to idle initiator %0d", i));
        if (init_rvalid[i]) begin
          assert (pend[i]) else note_failure($sformatf("rvalid to initiator %0d unasked", i));
          if (pend[i] && chk_data[i])
            assert (init_rdata[i] == exp_rdata[i])
            else flag_mismatch("rdata", exp_rdata[i], init_rdata[i]);
          if (pend[i])
            assert (init_ropc[i] == exp_ropc[i])
            else flag_mismatch("ropc", exp_ropc[i], init_ropc[i]);
          pend[i] = 1'b0;
        end
        if (init_req[i] && init_gnt[i]) begin
          assert (!pend[i]) else note_failure($sformatf("initiator %0d granted twice", i));
          t = exp_target(init_addr[i], sh_cid, sh_alias, sh_hwpe);
          if (t == 2) begin
            for (int p = 0; p < NB_EXT; p++)
              assert (!(tgt_req[p] && tgt_gnt[p] && tgt_id[p] == oh))
              else note_failure($sformatf("config access leaked to port %0d", p));
            exp_ropc[i]  = !(init_addr[i][9:0] inside {10'h0, 10'h4});
            chk_data[i]  = init_we_n[i];
            exp_rdata[i] = (init_addr[i][9:0] == 10'h0) ? {26'd0, sh_cid} :
                           (init_addr[i][9:0] == 10'h4) ? {30'd0, sh_hwpe, sh_alias} : 32'd0;
            if (!init_we_n[i] && init_be[i][0] && init_addr[i][9:0] == 10'h0) begin
              sh_cid <= init_wdata[i][5:0];
            end else if (!init_we_n[i] && init_be[i][0] && init_addr[i][9:0] == 10'h4) begin
              sh_alias <= init_wdata[i][0];
              sh_hwpe  <= init_wdata[i][1];
            end
          end else begin
            k = (t < 2) ? t : t - 1;
            assert (tgt_req[k] && tgt_gnt[k])
            else note_failure($sformatf("initiator %0d transfer missing on port %0d", i, k));
            assert (tgt_id[k] == oh) else flag_mismatch("tgt_id", oh, tgt_id[k]);
            assert (tgt_addr[k] == init_addr[i])
            else flag_mismatch("addr", init_addr[i], tgt_addr[k]);
            assert (tgt_wdata[k] == init_wdata[i])
            else flag_mismatch("wdata", init_wdata[i], tgt_wdata[k]);
            assert (tgt_we_n[k] == init_we_n[i])
            else flag_mismatch("we_n", init_we_n[i], tgt_we_n[k]);
            assert (tgt_be[k] == init_be[i]) else flag_mismatch("be", init_be[i], tgt_be[k]);
            exp_rdata[i] = init_addr[i] ^ t;
            chk_data[i]  = 1'b1;
            // only the error target flags its answer
            exp_ropc[i]  = (t == 9);
          end
          pend[i] = 1'b1;
          if (fair_mode) begin
            for (int w = 0; w < NB_INIT; w++)
              if (w != i && waiting[w]) begin
                assert (!since[w][i])
                else note_failure($sformatf("initiator %0d won twice while %0d waited", i, w));
                since[w][i] = 1'b1;
              end
          end
          since[i]   = '0;
          waiting[i] = 1'b0;
        end
      end
      for (int i = 0; i < NB_INIT; i++)
        if (fair_mode && init_req[i] && !init_gnt[i]) waiting[i] = 1'b1;
    end
  end

  task automatic access(input int i, input logic [31:0] addr, input logic we_n,
                        input logic [3:0] be, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic ropc);
    int n;
    rdata = '0;
    ropc  = 1'b0;
    @(posedge clk);
    init_req[i]   <= 1'b1;
    init_addr[i]  <= addr;
    init_we_n[i]  <= we_n;
    init_be[i]    <= be;
    init_wdata[i] <= wdata;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!init_gnt[i] && n < TMO);
    init_req[i] <= 1'b0;
    if (!init_gnt[i]) begin
      note_failure($sformatf("initiator %0d got no gnt for %h", i, addr));
      return;
    end
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!init_rvalid[i] && n < TMO);
    if (!init_rvalid[i]) note_failure($sformatf("initiator %0d got no rvalid for %h", i, addr));
    rdata = init_rdata[i];
    ropc  = init_ropc[i];
  endtask

  task automatic burst(input int i, input int n, input bit mixed);
    logic [31:0] rd;
    logic        op;
    int          idx;
    for (int c = 0; c < n; c++) begin
      idx = mixed ? ({$random(seed)} % NB_TARGETS) : 5;
      if (idx == 2 || idx == 8) idx = 4;
      access(i, periph_addr(sh_cid, idx, i * 64 + c * 4), c[0], 4'hf, $random(seed), rd, op);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test      = name;
    errs_at_start = errors;
  endtask

  task automatic close_test();
    // the monitor has seen the last response by the falling edge
    @(negedge clk);
    tests_run++;
    assert (pend == '0) else note_failure("responses still outstanding");
    if (errors != errs_at_start) tests_failed++;
    $display("test %-10s %s", cur_test, (errors == errs_at_start) ? "ok" : "failed");
  endtask

  initial begin
    repeat (200000) @(posedge clk);
    $display("simulation stopped by the watchdog");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic        op;
    int          n;
    init_req   = '0;
    init_addr  = '0;
    init_we_n  = '1;
    init_be    = '0;
    init_wdata = '0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!rst_n && n < TMO);
    if (!rst_n) note_failure("reset was never released");

    begin_test("routing");
    for (int i = 0; i < NB_INIT; i++)
      for (int idx = 0; idx < NB_TARGETS; idx++)
        if (idx != 8)
          access(i, periph_addr(sh_cid, idx, i * 8), (idx == 2) | idx[0], 4'(idx + 1),
                 $random(seed), rd, op);
    close_test();

    begin_test("decode");
    access(1, 32'h2000_0040, 1'b1, 4'hf, 32'd0, rd, op);
    access(1, periph_addr(sh_cid, 4, 0) | 32'h0000_4000, 1'b1, 4'hf, 32'd0, rd, op);
    access(2, periph_addr(sh_cid, 12, 0), 1'b0, 4'h3, 32'h1234_5678, rd, op);
    access(2, periph_addr(sh_cid, 8, 0), 1'b1, 4'hf, 32'd0, rd, op);
    access(3, 32'h1010_0400, 1'b1, 4'hf, 32'd0, rd, op);
    access(0, periph_addr(sh_cid, 1, 16), 1'b0, 4'hf, 32'hcafe_0001, rd, op);
    close_test();

    begin_test("fairness");
    fair_mode = 1'b1;
    fork
      burst(0, 8, 1'b0);
      burst(1, 8, 1'b0);
      burst(2, 8, 1'b0);
      burst(3, 8, 1'b0);
    join
    fair_mode = 1'b0;
    close_test();

    begin_test("response");
    fork
      burst(0, 12, 1'b1);
      burst(1, 12, 1'b1);
      burst(2, 12, 1'b1);
      burst(3, 12, 1'b1);
    join
    close_test();

    begin_test("config");
    access(0, periph_addr(sh_cid, 2, 0), 1'b0, 4'h1, 32'd5, rd, op);
    access(1, periph_addr(sh_cid, 2, 0), 1'b0, 4'he, 32'd7, rd, op);
    access(2, periph_addr(sh_cid, 2, 0), 1'b1, 4'hf, 32'd0, rd, op);
    assert (rd == 32'd5) else flag_mismatch("cluster id readback", 32'd5, rd);
    access(3, periph_addr(sh_cid, 2, 4), 1'b0, 4'h1, 32'd3, rd, op);
    access(0, periph_addr(sh_cid, 2, 4), 1'b1, 4'hf, 32'd0, rd, op);
    assert (rd == 32'd3) else flag_mismatch("control readback", 32'd3, rd);
    access(1, periph_addr(sh_cid, 2, 12'h10), 1'b1, 4'hf, 32'd0, rd, op);
    assert (rd == 32'd0) else flag_mismatch("unknown offset rdata", 32'd0, rd);
    assert (op) else flag_mismatch("unknown offset ropc", 32'd1, op);
    // old cluster 0 now lies outside
    access(2, periph_addr(6'd0, 4, 0), 1'b1, 4'hf, 32'd0, rd, op);
    access(3, periph_addr(6'd5, 4, 0), 1'b0, 4'hf, 32'h0bad_f00d, rd, op);
    access(0, 32'h1220_0000 + (6 << 10), 1'b1, 4'hf, 32'd0, rd, op);
    access(1, periph_addr(sh_cid, 2, 4), 1'b0, 4'h1, 32'd1, rd, op);
    access(2, periph_addr(sh_cid, 3, 0), 1'b1, 4'hf, 32'd0, rd, op);
    close_test();

    repeat (3) @(posedge clk);
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
rtl/periph_xbar_pkg.sv
rtl/periph_addr_decode.sv
rtl/periph_rr_arbiter.sv
rtl/periph_resp_router.sv
rtl/periph_cfg_regs.sv
rtl/periph_xbar.sv
rtl/periph_subsys_top.sv
tb/tb_clk_gen.sv
tb/tb_target_model.sv
tb/periph_subsys_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove the build directory and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module periph_subsys_tb \
		-Mdir obj_dir -o periph_subsys_sim
	./obj_dir/periph_subsys_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
